// ==== Bender.yml ====
package:
  name: riscv64_lui_core

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_core_pkg.sv
      - hw/rv_bus_if.sv
      - hw/instr_fetch.sv
      - hw/lui_execute.sv
      - hw/irq_key_mover.sv
      - hw/mmio_peripherals.sv
      - hw/riscv64_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/tb_riscv64.sv

// ==== filelist.f ====
+incdir+hw
hw/rv_core_pkg.sv
hw/rv_bus_if.sv
hw/instr_fetch.sv
hw/lui_execute.sv
hw/irq_key_mover.sv
hw/mmio_peripherals.sv
hw/riscv64_top.sv
verification/tb_riscv64.sv

// ==== hw/instr_fetch.sv ====
module instr_fetch
    import rv_core_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  instr_t instruction,
    output pc_t    pc,
    output instr_t ir,
    output logic   heartbeat
);

    // Free-running program counter
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= '0;
        end else begin
            pc <= pc + 32'd4; // One word per cycle, no branches
        end
    end

    // Instruction register
    // Whatever sits on the instruction bus is taken every edge
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir <= '0;
        end else begin
            ir <= instruction;
        end
    end

    // Liveness toggle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            heartbeat <= 1'b0;
        end else begin
            heartbeat <= ~heartbeat; // Half the clock rate
        end
    end

endmodule

// ==== hw/irq_key_mover.sv ====
`include "rv_core_config.svh"

module irq_key_mover
    import rv_core_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  irq_vec_t interrupt_vector,
    rv_bus_if.master bus,
    output logic     interrupt_done
);

    mover_state_t state;

    // Sequencer and bus strobes
    // Strobes are registered, so each phase shows one cycle after its state
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state            <= MOVER_IDLE;
            bus.read_enable  <= 1'b0;
            bus.write_enable <= 1'b0;
            bus.address      <= '0;
            interrupt_done   <= 1'b0;
        end else begin
            bus.read_enable  <= 1'b0; // Single-cycle strobes by default
            bus.write_enable <= 1'b0;
            interrupt_done   <= 1'b0;
            case (state)
                MOVER_IDLE: begin
                    // Other vectors are simply ignored
                    if (interrupt_vector == `KEY_IRQ_VECTOR) begin
                        state <= MOVER_READ;
                    end
                end
                MOVER_READ: begin
                    bus.address     <= `KEY_BASE;
                    bus.read_enable <= 1'b1; // Key word comes back this cycle
                    state           <= MOVER_WRITE;
                end
                MOVER_WRITE: begin
                    bus.address      <= `ART_BASE;
                    bus.write_enable <= 1'b1;
                    interrupt_done   <= 1'b1; // Flagged in the write cycle
                    state            <= MOVER_IDLE;
                end
                default: begin
                    state <= MOVER_IDLE;
                end
            endcase
        end
    end

    // Captured key word
    // Sampled at the end of the read cycle, driven during the write cycle
    always_ff @(posedge clk) begin
        if (state == MOVER_WRITE) begin
            bus.write_data <= bus.read_data;
        end
    end

endmodule

// ==== hw/lui_execute.sv ====
`include "rv_core_config.svh"

module lui_execute
    import rv_core_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  instr_t   ir,
    input  reg_idx_t reg_index,
    output xword_t   reg_value
);

    // Integer register file
    xword_t regs [0:`NUM_REGS-1];

    logic [6:0] opcode;
    reg_idx_t   rd;
    xword_t     imm_u;
    logic       is_lui;

    // U-type fields
    assign opcode = ir[6:0];
    assign rd     = ir[11:7];

    // Upper 20 bits into [31:12], sign extended from bit 31
    assign imm_u = {{(`XLEN-32){ir[31]}}, ir[31:12], 12'b0};

    assign is_lui = (opcode == `OPCODE_LUI);

    // Write port
    // x0 never written, so it stays at its reset value
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (is_lui && (rd != '0)) begin
            regs[rd] <= imm_u; // Other opcodes leave the file alone
        end
    end

    // Debug read port, asynchronous
    assign reg_value = (reg_index == '0) ? '0 : regs[reg_index]; // x0 hardwired

endmodule

// ==== hw/mmio_peripherals.sv ====
`include "rv_core_config.svh"

module mmio_peripherals
    import rv_core_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    rv_bus_if.slave bus,
    input  xword_t  key_data,
    input  logic    key_load,
    output xword_t  art_data,
    output logic    art_strobe
);

    xword_t key_reg;
    logic   key_hit;
    logic   art_hit;

    // Address decode
    assign key_hit = bus.read_enable && (bus.address == `KEY_BASE);
    assign art_hit = bus.write_enable && (bus.address == `ART_BASE);

    // Keyboard register, loaded from outside
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            key_reg <= '0;
        end else if (key_load) begin
            key_reg <= key_data;
        end
    end

    // Read mux
    // Unmapped reads return zero
    assign bus.read_data = key_hit ? key_reg : '0;

    // Display register
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            art_data   <= '0;
            art_strobe <= 1'b0;
        end else begin
            art_strobe <= art_hit; // One cycle after the write
            if (art_hit) begin
                art_data <= bus.write_data; // Other addresses dropped
            end
        end
    end

endmodule

// ==== hw/riscv64_top.sv ====
module riscv64_top
    import rv_core_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    // Instruction stream
    input  instr_t   instruction,
    output pc_t      pc,
    output instr_t   ir,
    output logic     heartbeat,

    // Register file debug port
    input  reg_idx_t reg_index,
    output xword_t   reg_value,

    // Interrupt request and completion
    input  irq_vec_t interrupt_vector,
    output logic     interrupt_done,

    // Keyboard side
    input  xword_t   key_data,
    input  logic     key_load,

    // Display side
    output xword_t   art_data,
    output logic     art_strobe
);

    // Internal memory-mapped bus
    rv_bus_if bus0 ();

    // Fetch stage
    instr_fetch fetch0 (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .pc          (pc),
        .ir          (ir),
        .heartbeat   (heartbeat)
    );

    // LUI execute and register file
    lui_execute exec0 (
        .clk       (clk),
        .reset     (reset),
        .ir        (ir),
        .reg_index (reg_index),
        .reg_value (reg_value)
    );

    // Hardwired handler for the key vector, bus master
    irq_key_mover mover0 (
        .clk              (clk),
        .reset            (reset),
        .interrupt_vector (interrupt_vector),
        .bus              (bus0.master),
        .interrupt_done   (interrupt_done)
    );

    // Key and art registers, bus slave
    mmio_peripherals periph0 (
        .clk        (clk),
        .reset      (reset),
        .bus        (bus0.slave),
        .key_data   (key_data),
        .key_load   (key_load),
        .art_data   (art_data),
        .art_strobe (art_strobe)
    );

endmodule

// ==== hw/rv_bus_if.sv ====
// Memory-mapped bus between the interrupt handler and the peripherals
interface rv_bus_if
    import rv_core_pkg::*;
();

    addr_t  address;
    xword_t write_data;
    logic   write_enable; // Write lands on the next rising edge
    logic   read_enable;
    xword_t read_data;    // Combinational, same cycle as read_enable

    modport master (
        output address,
        output write_data,
        output write_enable,
        output read_enable,
        input  read_data
    );

    modport slave (
        input  address,
        input  write_data,
        input  write_enable,
        input  read_enable,
        output read_data
    );

endinterface

// ==== hw/rv_core_config.svh ====
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Core widths, fixed by RV64
`define XLEN 64
`define NUM_REGS 32 // x0..x31

// Memory-mapped peripheral addresses
`define ART_BASE 64'h8000_0000 // Display word, write only
`define KEY_BASE 64'h8000_0010 // Keyboard word, read only

// Only interrupt vector serviced by the hardwired handler
`define KEY_IRQ_VECTOR 4'd1

// Major opcode of LUI
`define OPCODE_LUI 7'b0110111

`endif

// ==== hw/rv_core_pkg.sv ====
`include "rv_core_config.svh"

package rv_core_pkg;

    // Data path word
    typedef logic [`XLEN-1:0] xword_t;

    // Bus address, full width
    typedef logic [63:0] addr_t;

    // Raw 32-bit instruction
    typedef logic [31:0] instr_t;

    // Program counter, byte address
    typedef logic [31:0] pc_t;

    typedef logic [4:0] reg_idx_t; // Register file index
    typedef logic [3:0] irq_vec_t; // Incoming interrupt vector

    // Interrupt handler sequence
    typedef enum logic [1:0] {
        MOVER_IDLE,  // Waiting for the key vector
        MOVER_READ,  // Read of the key register armed
        MOVER_WRITE  // Write to the art register armed
    } mover_state_t;

endpackage

// ==== verification/tb_riscv64.sv ====
`include "rv_core_config.svh"

module tb_riscv64
    import rv_core_pkg::*;
();

    localparam int MAX_CYCLES    = 1000; // Reset + ~235 execute + 20 transfers of 8 + margin
    localparam int RESET_CYCLES  = 16;
    localparam int NUM_INSTR     = 200;
    localparam int NUM_XFERS     = 20;
    localparam int IGNORE_CYCLES = 10;
    localparam int DRAIN_CYCLES  = 4;    // Longest vector-to-strobe distance plus one

    logic     clk;
    logic     reset;
    instr_t   instruction;
    pc_t      pc;
    instr_t   ir;
    logic     heartbeat;
    reg_idx_t reg_index;
    xword_t   reg_value;
    irq_vec_t interrupt_vector;
    logic     interrupt_done;
    xword_t   key_data;
    logic     key_load;
    xword_t   art_data;
    logic     art_strobe;

    integer seed;
    int     cycle_count;
    int     run_edges;         // Rising edges seen with reset released
    instr_t last_instr;        // Instruction sampled at the previous edge
    xword_t model_regs [0:`NUM_REGS-1];
    xword_t model_art;         // Last word expected on the display

    riscv64_top dut0 (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .pc               (pc),
        .ir               (ir),
        .heartbeat        (heartbeat),
        .reg_index        (reg_index),
        .reg_value        (reg_value),
        .interrupt_vector (interrupt_vector),
        .interrupt_done   (interrupt_done),
        .key_data         (key_data),
        .key_load         (key_load),
        .art_data         (art_data),
        .art_strobe       (art_strobe)
    );

    always #20 clk = ~clk; // Period 40

    // Expected register value of an instruction, U-type immediate
    function automatic xword_t lui_value(input instr_t ins);
        logic [31:0] upper;
        upper = {ins[31:12], 12'h000};
        return {{32{upper[31]}}, upper}; // Sign extension to 64 bits
    endfunction

    task automatic stop_with_failure();
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
        stop_with_failure();
    endtask

    task automatic report_error(input string what);
        $display("error at %0t: %s", $time, what);
        stop_with_failure();
    endtask

    // Run length guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            report_error("run did not finish within the cycle limit");
        end
    end

    // Edge count and previous instruction, both taken at the rising edge
    always @(posedge clk) begin
        if (reset) begin
            run_edges <= run_edges + 1;
        end
        last_instr <= instruction;
    end

    // Fetch comparison, sampled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            assert (pc == pc_t'(run_edges * 4))
                else report_mismatch("pc", pc_t'(run_edges * 4), pc);
            assert (heartbeat === run_edges[0])
                else report_mismatch("heartbeat", run_edges[0], heartbeat);
            if (run_edges >= 1) begin
                assert (ir == last_instr) else report_mismatch("ir", last_instr, ir);
            end
        end
    end

    // Drive one instruction and track it in the register model
    task automatic issue_instr(input instr_t ins);
        @(posedge clk);
        #5;
        instruction = ins;
        if (ins[6:0] == `OPCODE_LUI && ins[11:7] != 5'd0) begin
            model_regs[ins[11:7]] = lui_value(ins); // x0 stays zero
        end
    endtask

    task automatic sweep_registers();
        for (int r = 0; r < `NUM_REGS; r++) begin
            @(posedge clk);
            #5;
            reg_index = reg_idx_t'(r);
            @(negedge clk);
            assert (reg_value == model_regs[r])
                else report_mismatch($sformatf("reg_value x%0d", r), model_regs[r], reg_value);
        end
    endtask

    // One key-to-art transfer, cycle by cycle from the vector sample
    task automatic run_key_transfer(input xword_t word);
        @(posedge clk);
        #5;
        key_data = word;
        key_load = 1'b1;
        @(posedge clk);
        #5;
        key_load         = 1'b0;
        interrupt_vector = `KEY_IRQ_VECTOR;
        @(posedge clk);   // Vector sampled here
        #5;
        interrupt_vector = 4'd0;
        model_art        = word;
        for (int k = 0; k < 6; k++) begin
            @(negedge clk);
            assert (interrupt_done === (k == 2))
                else report_mismatch("interrupt_done", (k == 2), interrupt_done);
            assert (art_strobe === (k == 3))
                else report_mismatch("art_strobe", (k == 3), art_strobe);
            if (k >= 3) begin
                assert (art_data == model_art)
                    else report_mismatch("art_data", model_art, art_data);
            end
        end
    endtask

    // Vectors other than the key vector must be ignored
    // Key register gets a new word first, so a stray copy would change art_data
    task automatic run_ignored_vectors();
        int     v;
        xword_t word;
        word = {$random(seed), $random(seed)};
        if (word == model_art) begin
            word = ~word;
        end
        @(posedge clk);
        #5;
        key_data = word;
        key_load = 1'b1;
        @(posedge clk);
        #5;
        key_load = 1'b0;
        for (int c = 0; c < IGNORE_CYCLES + DRAIN_CYCLES; c++) begin
            @(posedge clk);
            #5;
            if (c < IGNORE_CYCLES) begin
                v = $unsigned($random(seed)) % 15;
                if (v != 0) begin
                    v = v + 1; // Skip vector 1
                end
            end else begin
                v = 0; // Let late vectors reach the outputs
            end
            interrupt_vector = irq_vec_t'(v);
            @(negedge clk);
            assert (interrupt_done === 1'b0)
                else report_mismatch("interrupt_done", 0, interrupt_done);
            assert (art_strobe === 1'b0) else report_mismatch("art_strobe", 0, art_strobe);
            assert (art_data == model_art) else report_mismatch("art_data", model_art, art_data);
        end
    endtask

    initial begin
        instr_t ins;
        xword_t word;
        seed             = 32'haf14_98a2;
        clk              = 1'b0;
        reset            = 1'b0;
        instruction      = '0;
        reg_index        = '0;
        interrupt_vector = '0;
        key_data         = '0;
        key_load         = 1'b0;
        cycle_count      = 0;
        run_edges        = 0;
        last_instr       = '0;
        model_art        = '0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end

        // Reset values while reset is held
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        assert (pc == '0) else report_mismatch("pc", 0, pc);
        assert (ir == '0) else report_mismatch("ir", 0, ir);
        assert (heartbeat === 1'b0) else report_mismatch("heartbeat", 0, heartbeat);
        assert (interrupt_done === 1'b0)
            else report_mismatch("interrupt_done", 0, interrupt_done);
        assert (art_strobe === 1'b0) else report_mismatch("art_strobe", 0, art_strobe);
        assert (art_data == '0) else report_mismatch("art_data", 0, art_data);
        @(posedge clk);
        #5;
        reset = 1'b1;

        // Random stream, roughly half LUI
        for (int i = 0; i < NUM_INSTR; i++) begin
            ins = $random(seed);
            if ($random(seed) & 1) begin
                ins[6:0] = `OPCODE_LUI;
            end
            issue_instr(ins);
        end
        issue_instr('0); // Opcode 0, no write
        repeat (2) @(posedge clk);
        sweep_registers();

        // Interrupt transfers with random key words
        for (int t = 0; t < NUM_XFERS; t++) begin
            word = {$random(seed), $random(seed)};
            run_key_transfer(word);
        end

        run_ignored_vectors();

        $display("Test OK");
        $finish;
    end

endmodule
